// File: include/spidergon_consts.svh
// spidergon node sizing constants: node count, flit widths, vc count, fifo depth, port counts
`ifndef SPIDERGON_CONSTS_SVH
`define SPIDERGON_CONSTS_SVH

// ring size and node id width
`define SPIDERGON_NUM_NODES 8
`define SPIDERGON_NODE_W 3

// flit data field, excludes kind and vc
`define SPIDERGON_DATA_W 16

// virtual channels per input port
`define SPIDERGON_NUM_VC 2
`define SPIDERGON_VC_W 1
`define SPIDERGON_FIFO_DEPTH 2 // flits held by one vc

// anticlockwise, clockwise, across
`define SPIDERGON_NUM_IN 3
`define SPIDERGON_NUM_OUT 4 // neighbours plus cpu ejection

// head flit data is dest, src, then this many payload bits
`define SPIDERGON_HEAD_PAYLOAD_W 10

`endif

// File: verilog/spidergon_pkg.sv
// flit, node id and direction types plus spidergon routing and head field helpers
`default_nettype none

`include "spidergon_consts.svh"

package spidergon_pkg;

	// top two bits of every flit
	typedef enum logic [1:0]
	{
		FLIT_TAIL = 2'b00,
		FLIT_HEAD = 2'b01,
		FLIT_BODY = 2'b10,
		FLIT_SINGLE = 2'b11 // one-flit packet, head and tail at once
	} flit_kind_e;

	typedef logic [`SPIDERGON_NODE_W-1:0] node_id_t;

	// port index, shared by inputs and the first three outputs
	typedef enum logic [1:0]
	{
		DIR_ACW = 2'd0,
		DIR_CW = 2'd1,
		DIR_ACROSS = 2'd2,
		DIR_LOCAL = 2'd3
	} dir_e;

	typedef struct packed
	{
		flit_kind_e kind;
		logic [`SPIDERGON_VC_W-1:0] vc; // vc index at the sending node
		logic [`SPIDERGON_DATA_W-1:0] data; // head: {dest, src, payload}
	} flit_t;

	// shortest path on the ring, across covers the three far nodes
	function automatic dir_e route_dir(node_id_t dest, node_id_t cur);
		node_id_t rel;
		rel = node_id_t'((int'(dest) + `SPIDERGON_NUM_NODES - int'(cur)) % `SPIDERGON_NUM_NODES);
		case (rel)
			3'd0: return DIR_LOCAL;
			3'd1, 3'd2: return DIR_CW;
			3'd6, 3'd7: return DIR_ACW;
			default: return DIR_ACROSS; // distance 3..5
		endcase
	endfunction

	// dest sits right above the source id
	function automatic node_id_t head_dest(flit_t f);
		return f.data[`SPIDERGON_HEAD_PAYLOAD_W + `SPIDERGON_NODE_W +: `SPIDERGON_NODE_W];
	endfunction

	function automatic logic is_head_kind(flit_kind_e k);
		return (k == FLIT_HEAD) || (k == FLIT_SINGLE);
	endfunction

endpackage

`default_nettype wire

// File: verilog/rr_arbiter.sv
// round-robin arbiter with one-hot grant and rotating priority pointer
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter
#(
	parameter int N = 2
)
(
	input wire clk,
	input wire reset,
	input wire [N-1:0] req,
	output logic [N-1:0] grant
);

	localparam int PTR_W = (N > 1) ? $clog2(N) : 1;

	logic [PTR_W-1:0] ptr; // highest priority index this cycle
	logic [PTR_W-1:0] win; // index of the granted requester
	logic found;
	int idx;

	// scan from ptr upwards with wrap, first requester wins
	always_comb
	begin
		grant = '0;
		win = ptr;
		found = 1'b0;
		idx = 0;
		for (int i = 0; i < N; i++)
		begin
			idx = (int'(ptr) + i) % N;
			if (!found && req[idx])
			begin
				grant[idx] = 1'b1;
				win = PTR_W'(idx);
				found = 1'b1;
			end
		end
	end

	// winner drops to lowest priority
	always_ff @(posedge clk)
	begin
		if (reset)
			ptr <= '0;
		else if (found)
			ptr <= (int'(win) == N - 1) ? '0 : win + 1'b1;
	end

endmodule

`default_nettype wire

// File: verilog/vc_fifo.sv
// two-entry circular flit fifo for one virtual channel, push and pop in the same cycle
`timescale 1ns/1ps
`default_nettype none

`include "spidergon_consts.svh"

module vc_fifo import spidergon_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire push,
	input wire flit_t push_flit,
	input wire pop,
	output flit_t head_flit,
	output logic empty,
	output logic full
);

	localparam int DEPTH = `SPIDERGON_FIFO_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	flit_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_push;
	logic do_pop;

	assign empty = (count == '0);
	assign full = (count == CNT_W'(DEPTH));
	assign head_flit = mem[rd_ptr]; // fall-through read

	// guarded so a bad request cannot corrupt the count
	assign do_pop = pop && !empty;
	assign do_push = push && (!full || do_pop); // full slot frees on pop

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= push_flit;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	// upstream must watch vc_full
	a_no_overflow: assert property (@(posedge clk) disable iff (reset)
		push && full |-> pop)
		else $error("vc_fifo: push into full fifo");

	// output side only grants nonempty vcs
	a_no_underflow: assert property (@(posedge clk) disable iff (reset)
		pop |-> !empty)
		else $error("vc_fifo: pop from empty fifo");

endmodule

`default_nettype wire

// File: verilog/input_port.sv
// input port: vc reservation, upstream tag match, vc rewrite, per-vc route and release
`timescale 1ns/1ps
`default_nettype none

`include "spidergon_consts.svh"

module input_port import spidergon_pkg::*;
#(
	parameter node_id_t NODE_ID = '0,
	parameter dir_e IN_DIR = DIR_ACW, // selects this port's grant bits
	localparam int NUM_VC = `SPIDERGON_NUM_VC,
	localparam int NUM_REQ = `SPIDERGON_NUM_IN * `SPIDERGON_NUM_VC
)
(
	input wire clk,
	input wire reset,
	input wire flit_t in_flit,
	input wire in_valid,
	output logic [NUM_VC-1:0] vc_free,
	output logic [NUM_VC-1:0] vc_full,
	output flit_t [NUM_VC-1:0] head_flit,
	output logic [NUM_VC-1:0] nonempty,
	output dir_e [NUM_VC-1:0] route,
	input wire [`SPIDERGON_NUM_OUT-1:0][NUM_REQ-1:0] grant_in
);

	logic is_head;
	logic [NUM_VC-1:0] reserved; // vc owned by a packet until its tail leaves
	logic [NUM_VC-1:0] head_req;
	logic [NUM_VC-1:0] head_sel; // one-hot vc picked for an arriving head
	logic [NUM_VC-1:0] tag_match;
	logic [NUM_VC-1:0] push;
	logic [NUM_VC-1:0] pop;
	logic [NUM_VC-1:0] empty;
	flit_t [NUM_VC-1:0] push_flit;

	assign is_head = is_head_kind(in_flit.kind);
	assign vc_free = ~reserved;
	assign nonempty = ~empty;

	// only arbitrate when a head is actually here, keeps the pointer honest
	assign head_req = (in_valid && is_head) ? ~reserved : '0;

	rr_arbiter #(.N(NUM_VC)) u_vc_arb
	(
		.clk(clk),
		.reset(reset),
		.req(head_req),
		.grant(head_sel)
	);

	// any output may pop us, at most one does per vc
	always_comb
	begin
		pop = '0;
		for (int o = 0; o < `SPIDERGON_NUM_OUT; o++)
			pop = pop | grant_in[o][int'(IN_DIR) * NUM_VC +: NUM_VC];
	end

	for (genvar v = 0; v < NUM_VC; v++)
	begin : g_vc
		logic reserved_q;
		logic open_q; // head seen, tail not yet enqueued
		logic [`SPIDERGON_VC_W-1:0] tag_q; // upstream vc of the owning packet
		dir_e route_q;
		logic release_vc;

		assign reserved[v] = reserved_q;
		assign route[v] = route_q;

		// a closed vc must not catch bodies of a newer packet reusing the tag
		assign tag_match[v] = reserved_q && open_q && (tag_q == in_flit.vc);
		assign push[v] = in_valid && (is_head ? head_sel[v] : tag_match[v]);

		// downstream sees our vc index
		assign push_flit[v] = '{kind: in_flit.kind,
			vc: `SPIDERGON_VC_W'(v),
			data: in_flit.data};

		assign release_vc = pop[v] && (head_flit[v].kind == FLIT_TAIL ||
			head_flit[v].kind == FLIT_SINGLE);

		always_ff @(posedge clk)
		begin
			if (reset)
			begin
				reserved_q <= 1'b0;
				open_q <= 1'b0;
			end
			else
			begin
				if (push[v] && is_head)
				begin
					reserved_q <= 1'b1;
					open_q <= (in_flit.kind == FLIT_HEAD); // single closes at once
				end
				else if (push[v] && in_flit.kind == FLIT_TAIL)
					open_q <= 1'b0;
				if (release_vc)
					reserved_q <= 1'b0; // free from the next cycle
			end
		end

		// route computed once per packet from the head
		always_ff @(posedge clk)
		begin
			if (push[v] && is_head)
			begin
				tag_q <= in_flit.vc;
				route_q <= route_dir(head_dest(in_flit), NODE_ID);
			end
		end

		vc_fifo u_fifo
		(
			.clk(clk),
			.reset(reset),
			.push(push[v]),
			.push_flit(push_flit[v]),
			.pop(pop[v]),
			.head_flit(head_flit[v]),
			.empty(empty[v]),
			.full(vc_full[v])
		);
	end

	// upstream sends a head only while some vc_free is high
	a_head_has_vc: assert property (@(posedge clk) disable iff (reset)
		in_valid && is_head |-> |head_sel)
		else $error("input_port %0d: head flit with no free vc", IN_DIR);

	// body or tail must belong to exactly one open packet
	a_body_has_vc: assert property (@(posedge clk) disable iff (reset)
		in_valid && !is_head |-> $onehot(tag_match))
		else $error("input_port %0d: body or tail with no owning vc", IN_DIR);

endmodule

`default_nettype wire

// File: verilog/output_port.sv
// output port: vc arbitration, wormhole lock, stall hold-off and registered flit output
`timescale 1ns/1ps
`default_nettype none

`include "spidergon_consts.svh"

module output_port import spidergon_pkg::*;
#(
	parameter dir_e OUT_DIR = DIR_LOCAL,
	localparam int NUM_REQ = `SPIDERGON_NUM_IN * `SPIDERGON_NUM_VC,
	localparam int IDX_W = $clog2(NUM_REQ)
)
(
	input wire clk,
	input wire reset,
	input wire stall, // downstream hold-off level
	input wire flit_t [NUM_REQ-1:0] head_flit,
	input wire [NUM_REQ-1:0] nonempty,
	input wire dir_e [NUM_REQ-1:0] route,
	output logic [NUM_REQ-1:0] grant,
	output flit_t out_flit,
	output logic out_valid
);

	logic [NUM_REQ-1:0] req;
	logic locked; // a packet is mid-flight on this output
	logic [IDX_W-1:0] lock_idx;
	logic [IDX_W-1:0] win_idx;
	flit_t win_flit;
	logic any_grant;

	// while locked only the owning vc competes
	always_comb
	begin
		for (int i = 0; i < NUM_REQ; i++)
		begin
			req[i] = nonempty[i] && (route[i] == OUT_DIR) && !stall &&
				(!locked || lock_idx == IDX_W'(i));
		end
	end

	rr_arbiter #(.N(NUM_REQ)) u_out_arb
	(
		.clk(clk),
		.reset(reset),
		.req(req),
		.grant(grant)
	);

	assign any_grant = |grant;

	// one-hot mux of the winning vc head
	always_comb
	begin
		win_idx = '0;
		win_flit = '0;
		for (int i = 0; i < NUM_REQ; i++)
		begin
			if (grant[i])
			begin
				win_idx = IDX_W'(i);
				win_flit = head_flit[i];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			out_valid <= 1'b0;
			locked <= 1'b0;
			lock_idx <= '0;
		end
		else
		begin
			out_valid <= any_grant; // low one cycle after stall rises
			if (any_grant && win_flit.kind == FLIT_HEAD)
			begin
				locked <= 1'b1;
				lock_idx <= win_idx;
			end
			else if (any_grant && win_flit.kind == FLIT_TAIL)
				locked <= 1'b0; // packet done, reopen arbitration
		end
	end

	always_ff @(posedge clk)
	begin
		if (any_grant)
			out_flit <= win_flit;
	end

	// each input port pops at most one flit per grant
	a_grant_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0(grant))
		else $error("output_port %0d: more than one vc granted", OUT_DIR);

	// body and tail only ever follow their own head
	a_body_in_lock: assert property (@(posedge clk) disable iff (reset)
		any_grant && (win_flit.kind == FLIT_BODY || win_flit.kind == FLIT_TAIL)
		|-> locked && win_idx == lock_idx)
		else $error("output_port %0d: body or tail outside its packet", OUT_DIR);

endmodule

`default_nettype wire

// File: verilog/spidergon_node.sv
// spidergon router node top: three input ports, three neighbour outputs and cpu ejection
`timescale 1ns/1ps
`default_nettype none

`include "spidergon_consts.svh"

module spidergon_node import spidergon_pkg::*;
#(
	parameter node_id_t NODE_ID = '0,
	localparam int NUM_IN = `SPIDERGON_NUM_IN,
	localparam int NUM_VC = `SPIDERGON_NUM_VC,
	localparam int NUM_REQ = `SPIDERGON_NUM_IN * `SPIDERGON_NUM_VC
)
(
	input wire clk,
	input wire reset,
	input wire flit_t [NUM_IN-1:0] in_flit, // indexed by dir_e
	input wire [NUM_IN-1:0] in_valid,
	output logic [NUM_IN-1:0][NUM_VC-1:0] vc_free,
	output logic [NUM_IN-1:0][NUM_VC-1:0] vc_full,
	output flit_t [NUM_IN-1:0] out_flit,
	output logic [NUM_IN-1:0] out_valid,
	input wire [NUM_IN-1:0] out_stall,
	output flit_t cpu_flit,
	output logic cpu_valid
);

	// flattened vc state, index is port * NUM_VC + vc
	flit_t [NUM_REQ-1:0] vc_head;
	logic [NUM_REQ-1:0] vc_nonempty;
	dir_e [NUM_REQ-1:0] vc_route;
	logic [`SPIDERGON_NUM_OUT-1:0][NUM_REQ-1:0] grant; // per output, per vc

	for (genvar p = 0; p < NUM_IN; p++)
	begin : g_in
		input_port #(.NODE_ID(NODE_ID), .IN_DIR(dir_e'(p))) u_in
		(
			.clk(clk),
			.reset(reset),
			.in_flit(in_flit[p]),
			.in_valid(in_valid[p]),
			.vc_free(vc_free[p]),
			.vc_full(vc_full[p]),
			.head_flit(vc_head[p*NUM_VC +: NUM_VC]),
			.nonempty(vc_nonempty[p*NUM_VC +: NUM_VC]),
			.route(vc_route[p*NUM_VC +: NUM_VC]),
			.grant_in(grant) // every output can pop any vc
		);
	end

	// neighbour links, each with its own stall
	for (genvar d = 0; d < NUM_IN; d++)
	begin : g_out
		output_port #(.OUT_DIR(dir_e'(d))) u_out
		(
			.clk(clk),
			.reset(reset),
			.stall(out_stall[d]),
			.head_flit(vc_head),
			.nonempty(vc_nonempty),
			.route(vc_route),
			.grant(grant[d]),
			.out_flit(out_flit[d]),
			.out_valid(out_valid[d])
		);
	end

	// cpu always accepts
	output_port #(.OUT_DIR(DIR_LOCAL)) u_out_local
	(
		.clk(clk),
		.reset(reset),
		.stall(1'b0),
		.head_flit(vc_head),
		.nonempty(vc_nonempty),
		.route(vc_route),
		.grant(grant[int'(DIR_LOCAL)]),
		.out_flit(cpu_flit),
		.out_valid(cpu_valid)
	);

endmodule

`default_nettype wire

// File: verification/clock_gen.sv
// testbench clock source and synchronous reset pulse
`timescale 1ns/1ps
`default_nettype none

module clock_gen
#(
	parameter int period = 10,
	parameter int reset_cycles = 2
)
(
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		reset = 1'b1; // held high for the first few edges
		repeat (reset_cycles) @(posedge clk);
		reset <= 1'b0;
	end

	always #(period / 2) clk = ~clk;

endmodule

`default_nettype wire

// File: verification/tb_spidergon_node.sv
// testbench for one spidergon node: packet table, reference routing, output checks, watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_spidergon_node import spidergon_pkg::*;
	();

	localparam int node_id = 2;
	localparam int clk_period = 10;
	localparam int num_rows = 13;
	localparam int num_tests = 5;

	// one row per packet: test, input port, dest, length, upstream tag, start cycle, stall cycles
	localparam int row_test [num_rows] = '{2, 2, 2, 2, 2, 2, 2, 2, 3, 4, 4, 4, 5};
	localparam int row_port [num_rows] = '{0, 1, 2, 0, 1, 2, 0, 1, 1, 0, 2, 1, 0};
	localparam int row_dest [num_rows] = '{0, 1, 2, 3, 4, 5, 6, 7, 5, 0, 0, 2, 3};
	localparam int row_len [num_rows] = '{1, 1, 1, 1, 1, 1, 1, 1, 4, 3, 3, 4, 4};
	localparam int row_tag [num_rows] = '{0, 1, 0, 1, 0, 1, 0, 1, 1, 0, 1, 0, 1};
	localparam int row_start [num_rows] = '{0, 0, 0, 2, 2, 2, 4, 4, 0, 0, 0, 1, 0};
	localparam int row_stall [num_rows] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 20};

	logic clk;
	logic reset;
	flit_t [2:0] in_flit;
	logic [2:0] in_valid;
	logic [2:0][1:0] vc_free;
	logic [2:0][1:0] vc_full;
	flit_t [2:0] out_flit;
	logic [2:0] out_valid;
	logic [2:0] out_stall;
	flit_t cpu_flit;
	logic cpu_valid;

	// expected flits of the running test, grouped into packets
	flit_kind_e exp_kind [64];
	logic [15:0] exp_data [64];
	int pkt_start [16];
	int pkt_len [16];
	int pkt_out [16]; // 0..2 neighbour, 3 cpu
	int pkt_state [16]; // 0 waiting, 1 arriving, 2 complete
	int n_exp;
	int n_pkt;

	// flits still to be driven
	flit_t snd_flit [64];
	int snd_port [64];
	int snd_start [64];
	logic snd_done [64];
	int n_snd;

	int cur_pkt [4]; // packet now arriving on each output
	int cur_pos [4];
	int stall_cnt [3];
	logic [2:0] stall_prev;
	logic [2:0] saw_resv;
	logic saw_full;
	logic [15:0] lfsr_state;
	int errors;
	int failed_tests;
	int cyc;

	clock_gen #(.period(clk_period), .reset_cycles(2)) u_clk
	(
		.clk(clk),
		.reset(reset)
	);

	spidergon_node #(.NODE_ID(3'(node_id))) uut
	(
		.clk(clk),
		.reset(reset),
		.in_flit(in_flit),
		.in_valid(in_valid),
		.vc_free(vc_free),
		.vc_full(vc_full),
		.out_flit(out_flit),
		.out_valid(out_valid),
		.out_stall(out_stall),
		.cpu_flit(cpu_flit),
		.cpu_valid(cpu_valid)
	);

	// taps 16,14,13,11
	function automatic logic [15:0] lfsr_next(logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [15:0] take_bits(int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[14:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// shortest path seen from this node, returns output index
	function automatic int expected_output(int dest);
		int rel;
		rel = (dest - node_id + 8) % 8;
		if (rel == 0)
			return 3;
		else if (rel == 1 || rel == 2)
			return 1;
		else if (rel == 6 || rel == 7)
			return 0;
		return 2;
	endfunction

	task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp)
		begin
			$display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	// expand one table row into expected packet and send list
	task automatic build_row(int r);
		int o;
		int len;
		flit_kind_e k;
		logic [15:0] d;
		logic [15:0] pay;
		o = expected_output(row_dest[r]);
		len = row_len[r];
		pkt_start[n_pkt] = n_exp;
		pkt_len[n_pkt] = len;
		pkt_out[n_pkt] = o;
		pkt_state[n_pkt] = 0;
		n_pkt++;
		for (int i = 0; i < len; i++)
		begin
			if (len == 1)
				k = FLIT_SINGLE;
			else if (i == 0)
				k = FLIT_HEAD;
			else if (i == len - 1)
				k = FLIT_TAIL;
			else
				k = FLIT_BODY;
			if (i == 0)
			begin
				pay = take_bits(10); // head keeps ten payload bits
				d = {3'(row_dest[r]), 3'((node_id + row_port[r] + 1) % 8), pay[9:0]};
			end
			else
				d = take_bits(16);
			exp_kind[n_exp] = k;
			exp_data[n_exp] = d;
			n_exp++;
			snd_flit[n_snd].kind = k;
			snd_flit[n_snd].vc = 1'(row_tag[r]); // upstream tag
			snd_flit[n_snd].data = d;
			snd_port[n_snd] = row_port[r];
			snd_start[n_snd] = row_start[r];
			snd_done[n_snd] = 1'b0;
			n_snd++;
		end
		if (o < 3 && row_stall[r] > 0)
			stall_cnt[o] = row_stall[r];
	endtask

	// one flit arriving on output o
	task automatic take_output(int o, flit_t f);
		int idx;
		if (cur_pkt[o] < 0)
		begin
			for (int k = 0; k < n_pkt; k++)
			begin
				if (cur_pkt[o] < 0 && pkt_state[k] == 0 && pkt_out[k] == o &&
					exp_data[pkt_start[k]] == f.data && is_head_kind(f.kind))
				begin
					cur_pkt[o] = k;
					cur_pos[o] = 0;
					pkt_state[k] = 1;
				end
			end
			if (cur_pkt[o] < 0)
			begin
				$display("unexpected flit %0h on output %0d at %0t", f, o, $time);
				errors++;
				return;
			end
		end
		idx = pkt_start[cur_pkt[o]] + cur_pos[o];
		check_value($sformatf("out_flit[%0d].kind", o), 32'(f.kind), 32'(exp_kind[idx]));
		check_value($sformatf("out_flit[%0d].data", o), 32'(f.data), 32'(exp_data[idx]));
		cur_pos[o]++;
		if (cur_pos[o] == pkt_len[cur_pkt[o]])
		begin
			pkt_state[cur_pkt[o]] = 2;
			cur_pkt[o] = -1;
		end
	endtask

	// samples pre-edge outputs
	task automatic watch_outputs();
		for (int o = 0; o < 3; o++)
		begin
			if (out_valid[o])
				take_output(o, out_flit[o]);
			if (stall_prev[o] && out_valid[o])
			begin
				$display("output %0d sent a flit while stalled at %0t", o, $time);
				errors++;
			end
			if (vc_free[o] != 2'b11)
				saw_resv[o] = 1'b1;
		end
		if (cpu_valid)
			take_output(3, cpu_flit);
		stall_prev = out_stall;
		if (vc_full != '0)
			saw_full = 1'b1;
	endtask

	// one flit every other cycle per port so flags always see the last push
	task automatic drive_inputs();
		int i;
		for (int p = 0; p < 3; p++)
		begin
			in_valid[p] <= 1'b0;
			i = 0;
			while (i < n_snd && (snd_done[i] || snd_port[i] != p))
				i++;
			if (!in_valid[p] && i < n_snd && cyc >= snd_start[i])
			begin
				if (is_head_kind(snd_flit[i].kind) ? (vc_free[p] != 2'b00) :
					(vc_full[p] == 2'b00))
				begin
					in_flit[p] <= snd_flit[i];
					in_valid[p] <= 1'b1;
					snd_done[i] = 1'b1;
				end
			end
		end
		for (int o = 0; o < 3; o++)
		begin
			out_stall[o] <= (stall_cnt[o] > 0);
			if (stall_cnt[o] > 0)
				stall_cnt[o]--;
		end
	endtask

	function automatic logic test_finished();
		for (int k = 0; k < n_pkt; k++)
			if (pkt_state[k] != 2)
				return 1'b0;
		for (int i = 0; i < n_snd; i++)
			if (!snd_done[i])
				return 1'b0;
		return (stall_cnt[0] == 0 && stall_cnt[1] == 0 && stall_cnt[2] == 0);
	endfunction

	initial
	begin
		string names [num_tests];
		int err_start;
		names = '{"reset", "routing", "wormhole", "contention", "stall"};
		in_flit = '0;
		in_valid = '0;
		out_stall = '0;
		lfsr_state = 16'd27;
		errors = 0;
		failed_tests = 0;
		stall_prev = '0;
		for (int o = 0; o < 4; o++)
			cur_pkt[o] = -1;
		@(posedge clk); // reset is already high by the first edge
		while (reset !== 1'b0)
			@(posedge clk);
		for (int t = 1; t <= num_tests; t++)
		begin
			err_start = errors;
			n_pkt = 0;
			n_exp = 0;
			n_snd = 0;
			cyc = 0;
			saw_resv = '0;
			saw_full = 1'b0;
			stall_cnt = '{0, 0, 0};
			if (t == 1)
			begin
				check_value("out_valid", 32'(out_valid), 32'h0);
				check_value("cpu_valid", 32'(cpu_valid), 32'h0);
				check_value("vc_free", 32'(vc_free), 32'h3f);
				check_value("vc_full", 32'(vc_full), 32'h0);
			end
			for (int r = 0; r < num_rows; r++)
				if (row_test[r] == t)
					build_row(r);
			while (!test_finished())
			begin
				@(posedge clk);
				watch_outputs();
				drive_inputs();
				cyc++;
			end
			repeat (3) // let the last release settle
			begin
				@(posedge clk);
				watch_outputs();
				drive_inputs();
			end
			if (t == 3)
			begin
				if (!saw_resv[1])
				begin
					$display("vc_free of port 1 never dropped for the packet");
					errors++;
				end
				check_value("vc_free", 32'(vc_free), 32'h3f);
			end
			if (t == 5 && !saw_full)
			begin
				$display("vc_full never rose while the output was stalled");
				errors++;
			end
			if (errors != err_start)
				failed_tests++;
			$display("test %0d %s: %s (%0d errors)", t, names[t-1],
				(errors == err_start) ? "pass" : "fail", errors - err_start);
		end
		$display("tests %0d, failed %0d, errors %0d", num_tests, failed_tests, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	// limit from total flits, stall time and a margin
	initial
	begin
		int lim;
		lim = 300;
		for (int r = 0; r < num_rows; r++)
			lim += row_len[r] * 4 + row_stall[r] + row_start[r] + 4;
		#(lim * clk_period);
		$display("watchdog expired after %0d cycles, packets did not all arrive", lim);
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+include
verilog/spidergon_pkg.sv
verilog/rr_arbiter.sv
verilog/vc_fifo.sv
verilog/input_port.sv
verilog/output_port.sv
verilog/spidergon_node.sv
verification/clock_gen.sv
verification/tb_spidergon_node.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert
TOP ?= tb_spidergon_node
FILELIST ?= files.f
OBJDIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT = Done: no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

$(OBJDIR)/V$(TOP): $(shell grep -v '^+' $(FILELIST)) include/spidergon_consts.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

test: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed" && exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
